// ==== isa_pkg.sv ====
package isa_pkg;

  // memory word and address
  typedef logic [15:0] word_t;  // one program word
  typedef logic [5:0] addr_t;  // word address into the 64 word RAM
  typedef logic [7:0] opcode_t;  // high byte of the first word of a pair

  // memory layout
  localparam int mem_depth = 64;  // words in the program RAM
  localparam addr_t program_base = 6'd32;  // first fetched address
  // addresses below program_base are the unused header area

  // run limits
  localparam int max_pairs = 12;  // pairs per run before L
  localparam int pair_cnt_w = $clog2(max_pairs + 1);  // width of the pair counter

  // opcodes, first word high byte
  // second word holds the operand, the jmp target for op_jmp
  localparam opcode_t op_jmp = 8'd1;  // target in low 6 bits of word 2
  localparam opcode_t op_ram2reg = 8'd2;  // ram -> reg
  localparam opcode_t op_reg2ram = 8'd3;  // reg -> ram
  localparam opcode_t op_num2reg = 8'd4;  // value -> reg
  localparam opcode_t op_int = 8'd15;  // interrupt, ends the run

endpackage

// ==== trace_pkg.sv ====
package trace_pkg;

  typedef logic [7:0] char_t;  // one ascii trace character

  // trace alphabet
  localparam char_t ch_start = "S";  // first char of every run
  localparam char_t ch_jmp = "J";
  localparam char_t ch_ram2reg = "I";
  localparam char_t ch_reg2ram = "N";
  localparam char_t ch_num2reg = "C";
  localparam char_t ch_int = "H";
  localparam char_t ch_other = "X";  // unknown opcode
  localparam char_t ch_end_of_mem = "E";  // next pair passes address 63
  localparam char_t ch_limit = "L";  // step limit hit

  // buffer between fetcher and transmitter
  localparam int fifo_depth = 16;  // longest run is 14 chars
  localparam int ptr_w = $clog2(fifo_depth);

  // uart bit timing
  localparam int clks_per_bit = 16;  // sim value, 868 at 100 MHz for 115200
  localparam int bit_timer_w = $clog2(clks_per_bit);

endpackage

// ==== program_ram.sv ====
`timescale 1ns/1ps

module program_ram (
  input  logic           clk,
  input  logic           prog_write,    // one word per high cycle
  input  isa_pkg::addr_t prog_address,
  input  isa_pkg::word_t prog_data,
  input  isa_pkg::addr_t rd_address,    // from the fetcher
  output isa_pkg::word_t rd_data        // valid one edge after rd_address
);

  import isa_pkg::*;

  word_t mem [mem_depth];  // program storage, contents kept across reset

  // write port
  always_ff @(posedge clk) begin
    if (prog_write) begin
      mem[prog_address] <= prog_data;  // takes effect on this edge
    end
  end

  // synchronous read port
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_address];  // old data on a same address write
  end

endmodule

// ==== instr_fetcher.sv ====
`timescale 1ns/1ps

module instr_fetcher (
  input  logic             clk,
  input  logic             read_address_ready,  // async reset, active high
  input  logic             start,               // ignored while a run is active
  input  isa_pkg::word_t   rd_data,             // one cycle after rd_address
  output isa_pkg::addr_t   rd_address,
  output logic             push,                // one char per high cycle
  output trace_pkg::char_t push_char
);

  import isa_pkg::*;
  import trace_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_rd1,       // address of word 1 on the bus
    st_rd2,       // word 1 returns and word 2 address goes out
    st_classify,  // word 2 returns
    st_finish     // class char out and next step chosen
  } state_t;

  state_t                state;
  addr_t                 pc;          // address of the current pair
  logic [6:0]            next_pc;     // extra msb shows running past the end
  logic [pair_cnt_w-1:0] pairs;       // pairs fetched in this run
  logic                  ending;      // E or L already pushed
  word_t                 word1;       // first word of the pair
  opcode_t               opcode;
  char_t                 class_char;
  logic                  at_mem_end;  // next pair would pass address 63
  logic                  at_limit;

  assign opcode = word1[15:8];
  assign rd_address = (state == st_rd2) ? pc + 6'd1 : pc;  // word 2 right after word 1
  assign at_mem_end = next_pc > 7'(mem_depth - 2);
  assign at_limit = pairs == pair_cnt_w'(max_pairs);

  // opcode to trace char
  always_comb begin
    case (opcode)
      op_jmp:     class_char = ch_jmp;
      op_ram2reg: class_char = ch_ram2reg;
      op_reg2ram: class_char = ch_reg2ram;
      op_num2reg: class_char = ch_num2reg;
      op_int:     class_char = ch_int;
      default:    class_char = ch_other;
    endcase
  end

  // word 1 capture
  always_ff @(posedge clk) begin
    if (state == st_rd2) begin
      word1 <= rd_data;
    end
  end

  always_ff @(posedge clk or posedge read_address_ready) begin
    if (read_address_ready) begin
      state <= st_idle;
      pc <= '0;
      next_pc <= '0;
      pairs <= '0;
      ending <= 1'b0;
      push <= 1'b0;
      push_char <= '0;
    end else begin
      push <= 1'b0;  // strobes last one cycle
      case (state)
        st_idle: begin
          if (start) begin
            pc <= program_base;
            pairs <= '0;
            ending <= 1'b0;
            push <= 1'b1;  // S one cycle after start
            push_char <= ch_start;
            state <= st_rd1;
          end
        end
        st_rd1: state <= st_rd2;
        st_rd2: state <= st_classify;
        st_classify: begin
          push <= 1'b1;
          push_char <= class_char;
          pairs <= pairs + 1'b1;
          if (opcode == op_jmp) begin
            next_pc <= {1'b0, rd_data[5:0]};  // jmp target from word 2
          end else begin
            next_pc <= {1'b0, pc} + 7'd2;
          end
          state <= st_finish;
        end
        st_finish: begin
          if (ending || opcode == op_int) begin
            state <= st_idle;  // running drops a cycle after the last push
          end else if (at_mem_end) begin
            push <= 1'b1;
            push_char <= ch_end_of_mem;
            ending <= 1'b1;
          end else if (at_limit) begin
            push <= 1'b1;
            push_char <= ch_limit;
            ending <= 1'b1;
          end else begin
            pc <= next_pc[5:0];  // in range here
            state <= st_rd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // no char leaves once the run is over
  a_idle_quiet: assert property (@(posedge clk) disable iff (read_address_ready)
    state == st_idle |-> !push);

endmodule

// ==== trace_fifo.sv ====
`timescale 1ns/1ps

module trace_fifo (
  input  logic             clk,
  input  logic             read_address_ready,  // async reset, active high
  input  logic             push,
  input  trace_pkg::char_t push_char,
  input  logic             pop,                 // drops head at the next edge
  output trace_pkg::char_t head_char,
  output logic             empty
);

  import trace_pkg::*;

  char_t            mem [fifo_depth];  // circular storage
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;             // 0 to fifo_depth
  logic             full;

  assign head_char = mem[rd_ptr];  // visible the cycle after the push
  assign empty = count == '0;
  assign full = count == (ptr_w + 1)'(fifo_depth);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_char;
    end
  end

  always_ff @(posedge clk or posedge read_address_ready) begin
    if (read_address_ready) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  // fetcher has no back-pressure
  a_no_overflow: assert property (@(posedge clk) disable iff (read_address_ready)
    push |-> !full);

  a_no_underflow: assert property (@(posedge clk) disable iff (read_address_ready)
    pop |-> !empty);

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic             clk,
  input  logic             read_address_ready,  // async reset, active high
  input  trace_pkg::char_t head_char,
  input  logic             empty,
  output logic             pop,                 // takes head_char
  output logic             tx                   // 8N1, lsb first, idles high
);

  import trace_pkg::*;

  logic                   busy;       // frame in progress
  logic [bit_timer_w-1:0] bit_timer;  // cycles within one bit
  logic [3:0]             bit_index;  // 0 start, 1..8 data, 9 stop
  char_t                  tx_data;    // latched char

  assign pop = !busy && !empty;

  always_ff @(posedge clk) begin
    if (pop) begin
      tx_data <= head_char;
    end
  end

  always_ff @(posedge clk or posedge read_address_ready) begin
    if (read_address_ready) begin
      busy <= 1'b0;
      bit_timer <= '0;
      bit_index <= '0;
      tx <= 1'b1;
    end else if (!busy) begin
      bit_timer <= '0;
      bit_index <= '0;
      if (!empty) begin
        busy <= 1'b1;
        tx <= 1'b0;  // start bit one cycle after pop
      end
    end else if (bit_timer == bit_timer_w'(clks_per_bit - 1)) begin
      bit_timer <= '0;
      if (bit_index == 4'd9) begin
        busy <= 1'b0;  // stop bit done so the line stays high
      end else begin
        bit_index <= bit_index + 1'b1;
        if (bit_index == 4'd8) begin
          tx <= 1'b1;  // stop bit
        end else begin
          tx <= tx_data[bit_index[2:0]];  // data bit k follows index k
        end
      end
    end else begin
      bit_timer <= bit_timer + 1'b1;
    end
  end

  // pops only while the line idles high between frames
  a_pop_idle: assert property (@(posedge clk) disable iff (read_address_ready)
    pop |-> tx);

endmodule

// ==== fetch_trace_top.sv ====
`timescale 1ns/1ps

module fetch_trace_top (
  input  logic           clk,
  input  logic           read_address_ready,  // async reset, active high
  input  logic           prog_write,
  input  isa_pkg::addr_t prog_address,
  input  isa_pkg::word_t prog_data,
  input  logic           start,
  output logic           tx
);

  import isa_pkg::*;
  import trace_pkg::*;

  addr_t rd_address;  // fetcher -> ram
  word_t rd_data;     // ram -> fetcher
  logic  push;        // fetcher -> fifo
  char_t push_char;
  char_t head_char;   // fifo -> uart
  logic  empty;
  logic  pop;         // uart -> fifo

  program_ram i_program_ram (
    .clk          (clk),
    .prog_write   (prog_write),
    .prog_address (prog_address),
    .prog_data    (prog_data),
    .rd_address   (rd_address),
    .rd_data      (rd_data)
  );

  instr_fetcher i_instr_fetcher (
    .clk                (clk),
    .read_address_ready (read_address_ready),
    .start              (start),
    .rd_data            (rd_data),
    .rd_address         (rd_address),
    .push               (push),
    .push_char          (push_char)
  );

  trace_fifo i_trace_fifo (
    .clk                (clk),
    .read_address_ready (read_address_ready),
    .push               (push),
    .push_char          (push_char),
    .pop                (pop),
    .head_char          (head_char),
    .empty              (empty)
  );

  uart_tx i_uart_tx (
    .clk                (clk),
    .read_address_ready (read_address_ready),
    .head_char          (head_char),
    .empty              (empty),
    .pop                (pop),
    .tx                 (tx)
  );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
  input  logic             clk,
  input  logic             read_address_ready,  // no decoding in reset
  input  logic             tx,                  // DUT serial line
  input  logic             exp_valid,           // one expected char per high cycle
  input  trace_pkg::char_t exp_char,
  output int               bytes_seen,          // frames decoded to the end
  output int               start_bits,          // falling edges taken as start
  output int               mismatches,
  output int               frame_errors
);

  import trace_pkg::*;

  char_t expected[$];  // chars still to come on tx

  always @(posedge clk) begin
    if (exp_valid) begin
      expected.push_back(exp_char);
    end
  end

  // frame decoder, samples each bit at its middle
  initial begin
    char_t rx_char;
    char_t want;
    bytes_seen = 0;
    start_bits = 0;
    mismatches = 0;
    frame_errors = 0;
    forever begin
      @(posedge clk);
      if (!read_address_ready && tx === 1'b0) begin
        start_bits++;
        repeat (clks_per_bit / 2 - 1) @(posedge clk);  // middle of start bit
        if (tx !== 1'b0) begin
          frame_errors++;
          $display("start bit on tx ended before its middle");
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(posedge clk);
            rx_char = {tx, rx_char[7:1]};  // lsb arrives first
          end
          repeat (clks_per_bit) @(posedge clk);
          if (tx !== 1'b1) begin
            frame_errors++;
            $display("stop bit after byte 0x%02h on tx was not high", rx_char);
          end
          if (expected.size() == 0) begin
            frame_errors++;
            $display("byte 0x%02h arrived on tx with nothing expected", rx_char);
          end else begin
            want = expected.pop_front();
            if (rx_char !== want) begin
              mismatches++;
              $display("Mismatch tx_char expected 0x%02h got 0x%02h", want, rx_char);
            end
          end
          bytes_seen++;
        end
      end
    end
  end

endmodule

// ==== tb_fetch_trace.sv ====
`timescale 1ns/1ps

module tb_fetch_trace;

  import isa_pkg::*;
  import trace_pkg::*;

  logic  clk;
  logic  read_address_ready;
  logic  prog_write;
  addr_t prog_address;
  word_t prog_data;
  logic  start;
  logic  tx;
  logic  exp_valid;     // loads one expected char into the checker
  char_t exp_char;
  int    bytes_seen;    // from the checker
  int    start_bits;
  int    mismatches;
  int    frame_errors;

  // cases as read from trace_cases.txt
  int           case_writes[$];
  bit           case_extra[$];   // second start in mid run
  int           case_len[$];
  logic [127:0] case_trace[$];   // hex chars, first char leftmost
  addr_t        wr_addr[$];
  word_t        wr_word[$];

  word_t model_mem [mem_depth];  // mirror of every word written
  char_t model_chars[$];         // trace built from the fetch rules
  int    tb_errors = 0;
  int    cycle_limit = 0;        // 0 until the cases are known
  int    cycles = 0;

  fetch_trace_top i_fetch_trace_top (
    .clk                (clk),
    .read_address_ready (read_address_ready),
    .prog_write         (prog_write),
    .prog_address       (prog_address),
    .prog_data          (prog_data),
    .start              (start),
    .tx                 (tx)
  );

  tb_checker i_tb_checker (
    .clk                (clk),
    .read_address_ready (read_address_ready),
    .tx                 (tx),
    .exp_valid          (exp_valid),
    .exp_char           (exp_char),
    .bytes_seen         (bytes_seen),
    .start_bits         (start_bits),
    .mismatches         (mismatches),
    .frame_errors       (frame_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, tx never delivered all expected bytes", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // char k of a trace held as one hex number
  function automatic char_t trace_byte(logic [127:0] trace, int len, int k);
    return char_t'(trace >> (8 * (len - 1 - k)));
  endfunction

  // walks model_mem by the fetch rules and fills model_chars
  task automatic run_model();
    addr_t   pc;
    int      nxt;
    int      pairs;
    bit      done;
    opcode_t op;
    pc = program_base;
    pairs = 0;
    done = 1'b0;
    model_chars.delete();
    model_chars.push_back(ch_start);
    while (!done) begin
      op = model_mem[pc][15:8];  // high byte of word 1
      case (op)
        op_jmp:     model_chars.push_back(ch_jmp);
        op_ram2reg: model_chars.push_back(ch_ram2reg);
        op_reg2ram: model_chars.push_back(ch_reg2ram);
        op_num2reg: model_chars.push_back(ch_num2reg);
        op_int:     model_chars.push_back(ch_int);
        default:    model_chars.push_back(ch_other);
      endcase
      pairs++;
      if (op == op_jmp) begin
        nxt = int'(model_mem[pc + 6'd1][5:0]);  // target in word 2
      end else begin
        nxt = int'(pc) + 2;
      end
      if (op == op_int) begin
        done = 1'b1;
      end else if (nxt > mem_depth - 2) begin
        model_chars.push_back(ch_end_of_mem);  // next pair passes 63
        done = 1'b1;
      end else if (pairs == max_pairs) begin
        model_chars.push_back(ch_limit);
        done = 1'b1;
      end else begin
        pc = addr_t'(nxt);
      end
    end
  endtask

  task automatic check_case_trace(int c);
    bit bad;
    run_model();
    bad = model_chars.size() != case_len[c];
    for (int k = 0; k < case_len[c] && !bad; k++) begin
      bad = model_chars[k] != trace_byte(case_trace[c], case_len[c], k);
    end
    if (bad) begin
      tb_errors++;
      $display("case %0d: trace in trace_cases.txt breaks the fetch rules", c);
    end
  endtask

  task automatic read_cases();
    int           fd;
    int           rc;
    int           pending;  // write lines left in this case
    int           n_wr;
    int           extra;
    int           len;
    logic [127:0] trace;
    logic [15:0]  a_val;
    logic [15:0]  d_val;
    string        line;
    pending = 0;
    fd = $fopen("trace_cases.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("cannot open trace_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") continue;  // blank or comment
      if (pending == 0) begin
        rc = $sscanf(line, "%d %d %d %h", n_wr, extra, len, trace);
        if (rc != 4 || len > 16) begin
          tb_errors++;
          $display("bad case line in trace_cases.txt: %s", line);
        end else begin
          case_writes.push_back(n_wr);
          case_extra.push_back(extra != 0);
          case_len.push_back(len);
          case_trace.push_back(trace);
          pending = n_wr;
        end
      end else begin
        rc = $sscanf(line, "%h %h", a_val, d_val);
        wr_addr.push_back(addr_t'(a_val));
        wr_word.push_back(d_val);
        pending--;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int wr_pos;
    int total;  // bytes expected so far
    read_address_ready <= 1'b1;
    prog_write <= 1'b0;
    prog_address <= '0;
    prog_data <= '0;
    start <= 1'b0;
    exp_valid <= 1'b0;
    exp_char <= '0;
    wr_pos = 0;
    total = 0;
    read_cases();
    cycle_limit = case_len.size() * 14 * 10 * clks_per_bit * 2 + 1000;
    repeat (2) @(posedge clk);
    read_address_ready <= 1'b0;
    repeat (200) @(posedge clk);  // line must stay idle without a start
    if (start_bits != 0) begin
      tb_errors++;
      $display("tx left idle before any start strobe");
    end
    for (int c = 0; c < case_len.size(); c++) begin
      for (int k = 0; k < case_writes[c]; k++) begin
        @(posedge clk);
        prog_write <= 1'b1;
        prog_address <= wr_addr[wr_pos];
        prog_data <= wr_word[wr_pos];
        model_mem[wr_addr[wr_pos]] = wr_word[wr_pos];
        wr_pos++;
      end
      @(posedge clk);
      prog_write <= 1'b0;
      check_case_trace(c);
      for (int k = 0; k < case_len[c]; k++) begin
        exp_valid <= 1'b1;
        exp_char <= trace_byte(case_trace[c], case_len[c], k);
        @(posedge clk);
      end
      exp_valid <= 1'b0;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      if (case_extra[c]) begin
        repeat (2) @(posedge clk);
        start <= 1'b1;  // fetcher is mid pair here
        @(posedge clk);
        start <= 1'b0;
      end
      total += case_len[c];
      while (bytes_seen < total) @(posedge clk);
    end
    repeat (400) @(posedge clk);  // room for a stray frame to show
    if (start_bits != total) begin
      tb_errors++;
      $display("tx sent %0d frames where %0d were expected", start_bits, total);
    end
    $display("error counts: %0d mismatch, %0d framing, %0d other",
             mismatches, frame_errors, tb_errors);
    if (mismatches + frame_errors + tb_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== trace_cases.txt ====
# case line: <writes> <extra start 0/1> <chars> <expected trace, hex bytes, first char leftmost>
# then <writes> lines: <address> <word>, both hex
5 0 6 5343494e5848
20 0400
22 0200
24 0300
26 7700
28 0f00
3 0 3 534a48
20 0100
21 0028
28 0f00
2 1 14 534a4a4a4a4a4a4a4a4a4a4a4a4c
20 0100
21 0020
8 0 9 534a43494e58434e45
20 0100
21 0034
34 0400
36 0200
38 0300
3a 0500
3c 0400
3e 0300
2 0 3 534948
20 0200
22 0f00

// ==== compile.f ====
isa_pkg.sv
trace_pkg.sv
program_ram.sv
instr_fetcher.sv
trace_fifo.sv
uart_tx.sv
fetch_trace_top.sv
tb_checker.sv
tb_fetch_trace.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary -f compile.f --top-module tb_fetch_trace -o tb_fetch_trace \
  && ./obj_dir/tb_fetch_trace | tee /dev/stderr | grep -q "Regression passed" \
  && exit 0 || exit 1
